// ==== src/l2_cache_pkg.sv ====
// L2 cache shared definitions
// Holds the cache geometry, the request and response operation codes and
// the packed structs that carry a request from one pipeline stage to the next

`default_nettype none

package l2_cache_pkg;
	// Requesters and their sub-indices
	localparam int NUM_CORES = 2;
	localparam int CORE_INDEX_WIDTH = 1;
	localparam int STRAND_INDEX_WIDTH = 2;
	localparam int NUM_STRANDS = 1 << STRAND_INDEX_WIDTH;
	localparam int L1_WAY_INDEX_WIDTH = 2;

	// L2 geometry; addresses are line addresses, so the low bits pick the set
	localparam int L2_WAYS = 4;
	localparam int L2_WAY_INDEX_WIDTH = $clog2(L2_WAYS);
	localparam int L2_SET_BITS = 4;
	localparam int L2_SETS = 1 << L2_SET_BITS;
	localparam int ADDRESS_BITS = 26;
	localparam int TAG_BITS = ADDRESS_BITS - L2_SET_BITS;
	localparam int LINE_BITS = 128;
	localparam int LINE_BYTES = LINE_BITS / 8;

	typedef enum logic [2:0] {
		l2req_load = 3'd0,
		l2req_store = 3'd1,
		l2req_flush = 3'd2,
		l2req_dinvalidate = 3'd3,
		l2req_iinvalidate = 3'd4,
		l2req_load_sync = 3'd5,
		l2req_store_sync = 3'd6
	} l2req_op_t;

	// A flush has no code of its own and is answered as a load
	typedef enum logic [1:0] {
		l2rsp_load_ack = 2'd0,
		l2rsp_store_ack = 2'd1,
		l2rsp_dinvalidate = 2'd2,
		l2rsp_iinvalidate = 2'd3
	} l2rsp_op_t;

	typedef struct packed {
		logic [CORE_INDEX_WIDTH-1:0] core;
		logic [1:0] unit;
		logic [STRAND_INDEX_WIDTH-1:0] strand;
		l2req_op_t op;
		logic [L1_WAY_INDEX_WIDTH-1:0] l1_way;
		logic [ADDRESS_BITS-1:0] address;
		logic [LINE_BYTES-1:0] store_mask;
		logic [LINE_BITS-1:0] data;
	} l2_request_t;

	// Output of the tag stage
	typedef struct packed {
		l2_request_t request;
		logic valid;
		logic cache_hit;
		logic is_fill;
		logic [L2_WAY_INDEX_WIDTH-1:0] l2_way;
		logic [LINE_BITS-1:0] fill_data;
		logic [NUM_CORES-1:0] l1_has_line;
		logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] dir_l1_way;
	} tag_result_t;

	// Output of the read/write stage, data is the line after the operation
	typedef struct packed {
		l2_request_t request;
		logic valid;
		logic cache_hit;
		logic is_fill;
		logic [NUM_CORES-1:0] l1_has_line;
		logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] dir_l1_way;
		logic [LINE_BITS-1:0] data;
		logic store_sync_success;
	} rw_result_t;

	typedef struct packed {
		logic status;
		logic [CORE_INDEX_WIDTH-1:0] core;
		logic [1:0] unit;
		logic [STRAND_INDEX_WIDTH-1:0] strand;
		l2rsp_op_t op;
		logic [NUM_CORES-1:0] update;
		logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] way;
		logic [ADDRESS_BITS-1:0] address;
		logic [LINE_BITS-1:0] data;
	} l2_response_t;
endpackage

`default_nettype wire

// ==== src/l2_cache_tag.sv ====
// L2 cache tag stage
// Looks the request up in the tag array, picks a round-robin victim for
// fills and keeps the L1 presence directory. Directory contents are read
// before they are updated, so the response reports the holders before this
// request changed them

`timescale 1ns/1ps
`default_nettype none

module l2_cache_tag(
	input logic clk,
	input logic reset,
	input logic l2req_valid,
	input l2_cache_pkg::l2_request_t l2req,
	input logic restart_valid,
	input l2_cache_pkg::l2_request_t restart_request,
	input logic [l2_cache_pkg::LINE_BITS-1:0] restart_data,
	output l2_cache_pkg::tag_result_t tag_result);

	import l2_cache_pkg::*;

	l2_request_t request;
	logic request_valid;
	logic [L2_SET_BITS-1:0] set_index;
	logic [TAG_BITS-1:0] request_tag;
	logic [TAG_BITS-1:0] tag_array [L2_SETS][L2_WAYS];
	logic [L2_WAYS-1:0] tag_valid [L2_SETS];
	logic [L2_WAY_INDEX_WIDTH-1:0] victim_way [L2_SETS];
	logic [NUM_CORES-1:0] dir_present [L2_SETS][L2_WAYS];
	logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] dir_way [L2_SETS][L2_WAYS];
	logic cache_hit;
	logic [L2_WAY_INDEX_WIDTH-1:0] hit_way;
	logic [L2_WAY_INDEX_WIDTH-1:0] access_way;
	logic install;
	logic update_dir;
	logic [NUM_CORES-1:0] present_now;
	logic [NUM_CORES-1:0] present_next;
	logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] way_now;
	logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] way_next;

	// A restarted miss always wins over a new request from the cores
	assign request = restart_valid ? restart_request : l2req;
	assign request_valid = restart_valid || l2req_valid;
	assign set_index = request.address[L2_SET_BITS-1:0];
	assign request_tag = request.address[ADDRESS_BITS-1 -: TAG_BITS];

	always_comb
	begin
		cache_hit = 1'b0;
		hit_way = '0;
		for (int way = 0; way < L2_WAYS; way++)
		begin
			if (tag_valid[set_index][way] && tag_array[set_index][way] == request_tag)
			begin
				cache_hit = 1'b1;
				hit_way = L2_WAY_INDEX_WIDTH'(way);
			end
		end
	end

	// A fill only takes a new way when the line is not already resident
	assign install = restart_valid && !cache_hit;
	assign access_way = install ? victim_way[set_index] : hit_way;
	assign update_dir = request_valid && (cache_hit || restart_valid);

	// A freshly installed line starts with no L1 holders
	assign present_now = install ? '0 : dir_present[set_index][access_way];
	assign way_now = dir_way[set_index][access_way];

	always_comb
	begin
		present_next = present_now;
		way_next = way_now;
		if (request.op == l2req_load || request.op == l2req_load_sync)
		begin
			present_next[request.core] = 1'b1;
			way_next[request.core * L1_WAY_INDEX_WIDTH +: L1_WAY_INDEX_WIDTH] = request.l1_way;
		end
		else if (request.op == l2req_dinvalidate)
			present_next = '0;
	end

	// Tag and L1 way storage
	always_ff @(posedge clk)
	begin
		if (install)
			tag_array[set_index][access_way] <= request_tag;
		if (update_dir)
			dir_way[set_index][access_way] <= way_next;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int set = 0; set < L2_SETS; set++)
			begin
				tag_valid[set] <= '0;
				victim_way[set] <= '0;
				for (int way = 0; way < L2_WAYS; way++)
					dir_present[set][way] <= '0;
			end
			tag_result <= '0;
		end
		else
		begin
			if (install)
			begin
				tag_valid[set_index][access_way] <= 1'b1;
				victim_way[set_index] <= victim_way[set_index] + 1'b1;
			end
			if (update_dir)
				dir_present[set_index][access_way] <= present_next;

			tag_result.request <= request;
			tag_result.valid <= request_valid;
			tag_result.cache_hit <= cache_hit;
			tag_result.is_fill <= restart_valid;
			tag_result.l2_way <= access_way;
			tag_result.fill_data <= restart_data;
			tag_result.l1_has_line <= present_now;
			tag_result.dir_l1_way <= way_now;
		end
	end
endmodule

`default_nettype wire

// ==== src/l2_cache_read_write.sv ====
// L2 cache read/write stage
// Reads the line picked by the tag stage, installs fill data, merges store
// bytes and tracks load/store sync reservations for every core and strand.
// The line after the operation goes on to the response stage

`timescale 1ns/1ps
`default_nettype none

module l2_cache_read_write(
	input logic clk,
	input logic reset,
	input l2_cache_pkg::tag_result_t tag_result,
	output l2_cache_pkg::rw_result_t rw_result);

	import l2_cache_pkg::*;

	localparam int NUM_SLOTS = NUM_CORES * NUM_STRANDS;

	l2_request_t request;
	logic [L2_SET_BITS-1:0] set_index;
	logic [LINE_BITS-1:0] data_array [L2_SETS][L2_WAYS];
	logic [ADDRESS_BITS-1:0] reservation_address [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] reservation_valid;
	logic [CORE_INDEX_WIDTH+STRAND_INDEX_WIDTH-1:0] slot;
	logic active;
	logic store_sync_success;
	logic do_store;
	logic write_line;
	logic [LINE_BITS-1:0] line_before;
	logic [LINE_BITS-1:0] merged_line;
	logic [LINE_BITS-1:0] line_after;

	assign request = tag_result.request;
	assign set_index = request.address[L2_SET_BITS-1:0];
	assign slot = {request.core, request.strand};

	// Only hits and fills touch the array, misses wait for their restart
	assign active = tag_result.valid && (tag_result.cache_hit || tag_result.is_fill);

	// Fill data comes first, so a store that missed merges on top of it
	assign line_before = tag_result.is_fill ? tag_result.fill_data
		: data_array[set_index][tag_result.l2_way];

	always_comb
	begin
		for (int byte_index = 0; byte_index < LINE_BYTES; byte_index++)
		begin
			merged_line[byte_index * 8 +: 8] = request.store_mask[byte_index]
				? request.data[byte_index * 8 +: 8] : line_before[byte_index * 8 +: 8];
		end
	end

	// A store_sync only goes through if this strand still holds the line
	assign store_sync_success = reservation_valid[slot]
		&& reservation_address[slot] == request.address;
	assign do_store = request.op == l2req_store
		|| (request.op == l2req_store_sync && store_sync_success);
	assign line_after = do_store ? merged_line : line_before;
	assign write_line = active && (tag_result.is_fill || do_store);

	always_ff @(posedge clk)
	begin
		if (write_line)
			data_array[set_index][tag_result.l2_way] <= line_after;
		if (active && request.op == l2req_load_sync)
			reservation_address[slot] <= request.address;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			reservation_valid <= '0;
			rw_result <= '0;
		end
		else
		begin
			if (active && request.op == l2req_load_sync)
				reservation_valid[slot] <= 1'b1;
			else if (active && do_store)
			begin
				// Any write to the line breaks every reservation on it
				for (int index = 0; index < NUM_SLOTS; index++)
				begin
					if (reservation_address[index] == request.address)
						reservation_valid[index] <= 1'b0;
				end
			end

			rw_result.request <= request;
			rw_result.valid <= tag_result.valid;
			rw_result.cache_hit <= tag_result.cache_hit;
			rw_result.is_fill <= tag_result.is_fill;
			rw_result.l1_has_line <= tag_result.l1_has_line;
			rw_result.dir_l1_way <= tag_result.dir_l1_way;
			rw_result.data <= line_after;
			rw_result.store_sync_success <= store_sync_success;
		end
	end
endmodule

`default_nettype wire

// ==== src/l2_cache_response.sv ====
// L2 cache response stage
// Builds the response packet for hits, fills, flushes and invalidations.
// Misses are dropped here, the fill unit replays them once memory answers.
// The update bits tell each L1 whether its copy must change

`timescale 1ns/1ps
`default_nettype none

module l2_cache_response(
	input logic clk,
	input logic reset,
	input l2_cache_pkg::rw_result_t rw_result,
	output logic l2rsp_valid,
	output l2_cache_pkg::l2_response_t l2rsp);

	import l2_cache_pkg::*;

	l2_request_t request;
	l2rsp_op_t response_op;
	logic respond;
	logic is_store;
	logic [NUM_CORES-1:0] update_next;
	logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] way_next;

	assign request = rw_result.request;
	assign is_store = request.op == l2req_store || request.op == l2req_store_sync;

	// Maintenance operations always answer, even when the line is absent
	assign respond = rw_result.valid && (rw_result.cache_hit || rw_result.is_fill
		|| request.op == l2req_flush
		|| request.op == l2req_dinvalidate
		|| request.op == l2req_iinvalidate);

	always_comb
	begin
		case (request.op)
			l2req_store, l2req_store_sync: response_op = l2rsp_store_ack;
			l2req_dinvalidate: response_op = l2rsp_dinvalidate;
			l2req_iinvalidate: response_op = l2rsp_iinvalidate;
			default: response_op = l2rsp_load_ack;
		endcase
	end

	// A failed store_sync changed nothing, so no L1 needs an update
	always_comb
	begin
		if (request.op == l2req_store_sync)
			update_next = rw_result.l1_has_line & {NUM_CORES{rw_result.store_sync_success}};
		else if (is_store || request.op == l2req_dinvalidate)
			update_next = rw_result.l1_has_line;
		else
			update_next = '0;
	end

	// Holders get their recorded L1 way, everyone else the requester's way
	always_comb
	begin
		for (int core = 0; core < NUM_CORES; core++)
		begin
			way_next[core * L1_WAY_INDEX_WIDTH +: L1_WAY_INDEX_WIDTH] = rw_result.l1_has_line[core]
				? rw_result.dir_l1_way[core * L1_WAY_INDEX_WIDTH +: L1_WAY_INDEX_WIDTH]
				: request.l1_way;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			l2rsp_valid <= 1'b0;
			l2rsp <= '0;
		end
		else
		begin
			l2rsp_valid <= respond;
			if (respond)
			begin
				l2rsp.status <= request.op == l2req_store_sync
					? rw_result.store_sync_success : 1'b1;
				l2rsp.core <= request.core;
				l2rsp.unit <= request.unit;
				l2rsp.strand <= request.strand;
				l2rsp.op <= response_op;
				l2rsp.update <= update_next;
				l2rsp.way <= way_next;
				l2rsp.address <= request.address;
				l2rsp.data <= rw_result.data;
			end
		end
	end
endmodule

`default_nettype wire

// ==== src/l2_cache_fill.sv ====
// L2 cache fill unit
// Catches a load or store that missed, reads its line from memory and
// replays the request into the tag stage as a fill. Only one miss is
// handled at a time

`timescale 1ns/1ps
`default_nettype none

module l2_cache_fill(
	input logic clk,
	input logic reset,
	input l2_cache_pkg::rw_result_t rw_result,
	output logic mem_read_valid,
	output logic [l2_cache_pkg::ADDRESS_BITS-1:0] mem_read_address,
	input logic mem_response_valid,
	input logic [l2_cache_pkg::LINE_BITS-1:0] mem_response_data,
	output logic restart_valid,
	output l2_cache_pkg::l2_request_t restart_request,
	output logic [l2_cache_pkg::LINE_BITS-1:0] restart_data,
	output logic fill_pending);

	import l2_cache_pkg::*;

	typedef enum logic [1:0] {
		fill_idle,
		fill_wait_memory,
		fill_restart
	} fill_state_t;

	fill_state_t state;
	l2_request_t miss_request;
	logic is_miss;

	// Maintenance operations answer without the line, so they never fetch
	assign is_miss = rw_result.valid && !rw_result.cache_hit && !rw_result.is_fill
		&& (rw_result.request.op == l2req_load || rw_result.request.op == l2req_store
		|| rw_result.request.op == l2req_load_sync
		|| rw_result.request.op == l2req_store_sync);

	// The replay enters the tag stage on the same edge memory answers
	assign restart_valid = state == fill_wait_memory && mem_response_valid;
	assign restart_request = miss_request;
	assign restart_data = mem_response_data;
	assign mem_read_address = miss_request.address;

	// Stays pending one more cycle while the replay sits in the tag stage
	assign fill_pending = state != fill_idle;

	always_ff @(posedge clk)
	begin
		if (state == fill_idle && is_miss)
			miss_request <= rw_result.request;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= fill_idle;
			mem_read_valid <= 1'b0;
		end
		else
		begin
			mem_read_valid <= state == fill_idle && is_miss;
			case (state)
				fill_idle:
					if (is_miss)
						state <= fill_wait_memory;
				fill_wait_memory:
					if (mem_response_valid)
						state <= fill_restart;
				default:
					state <= fill_idle;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== src/l2_cache.sv ====
// L2 cache top level
// Chains the tag, read/write and response stages, hangs the fill unit off
// the read/write stage and raises busy to keep a single miss in flight

`timescale 1ns/1ps
`default_nettype none

module l2_cache(
	input logic clk,
	input logic reset,
	input logic l2req_valid,
	input l2_cache_pkg::l2_request_t l2req,
	output logic busy,
	output logic l2rsp_valid,
	output l2_cache_pkg::l2_response_t l2rsp,
	output logic mem_read_valid,
	output logic [l2_cache_pkg::ADDRESS_BITS-1:0] mem_read_address,
	input logic mem_response_valid,
	input logic [l2_cache_pkg::LINE_BITS-1:0] mem_response_data);

	import l2_cache_pkg::*;

	tag_result_t tag_result;
	rw_result_t rw_result;
	logic restart_valid;
	l2_request_t restart_request;
	logic [LINE_BITS-1:0] restart_data;
	logic fill_pending;
	logic tag_miss;
	logic rw_miss;
	logic accept;

	// A miss anywhere in the pipe blocks new requests until it is filled
	assign tag_miss = tag_result.valid && !tag_result.cache_hit && !tag_result.is_fill;
	assign rw_miss = rw_result.valid && !rw_result.cache_hit && !rw_result.is_fill;
	assign busy = fill_pending || tag_miss || rw_miss;

	// Requests presented while busy are ignored
	assign accept = l2req_valid && !busy;

	l2_cache_tag l2_cache_tag_inst(
		.clk(clk),
		.reset(reset),
		.l2req_valid(accept),
		.l2req(l2req),
		.restart_valid(restart_valid),
		.restart_request(restart_request),
		.restart_data(restart_data),
		.tag_result(tag_result));

	l2_cache_read_write l2_cache_read_write_inst(
		.clk(clk),
		.reset(reset),
		.tag_result(tag_result),
		.rw_result(rw_result));

	l2_cache_response l2_cache_response_inst(
		.clk(clk),
		.reset(reset),
		.rw_result(rw_result),
		.l2rsp_valid(l2rsp_valid),
		.l2rsp(l2rsp));

	l2_cache_fill l2_cache_fill_inst(
		.clk(clk),
		.reset(reset),
		.rw_result(rw_result),
		.mem_read_valid(mem_read_valid),
		.mem_read_address(mem_read_address),
		.mem_response_valid(mem_response_valid),
		.mem_response_data(mem_response_data),
		.restart_valid(restart_valid),
		.restart_request(restart_request),
		.restart_data(restart_data),
		.fill_pending(fill_pending));
endmodule

`default_nettype wire

// ==== bench/l2_cache_assert.sv ====
// L2 cache protocol assertions
// Bound into the top level to watch the response strobe, the memory read
// pulses and the busy level while a memory read is open

`timescale 1ns/1ps
`default_nettype none

module l2_cache_assert(
	input logic clk,
	input logic reset,
	input logic l2req_valid,
	input logic busy,
	input logic l2rsp_valid,
	input logic mem_read_valid,
	input logic mem_response_valid);

	logic request_seen;
	logic read_outstanding;

	// Remembers that a request was taken and whether a memory read is open
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			request_seen <= 1'b0;
			read_outstanding <= 1'b0;
		end
		else
		begin
			if (l2req_valid && !busy)
				request_seen <= 1'b1;
			if (mem_read_valid)
				read_outstanding <= 1'b1;
			else if (mem_response_valid)
				read_outstanding <= 1'b0;
		end
	end

	response_needs_request: assert property (@(posedge clk) disable iff (reset)
		$rose(l2rsp_valid) |-> request_seen)
		else $error("response strobe rose before any request was accepted");

	// Memory must answer before the next read goes out
	single_memory_read: assert property (@(posedge clk) disable iff (reset)
		mem_read_valid |-> !read_outstanding)
		else $error("second memory read issued before the first was answered");

	// The fill unit waits from its memory read until memory answers
	busy_while_filling: assert property (@(posedge clk) disable iff (reset)
		(mem_read_valid || read_outstanding) |-> busy)
		else $error("busy is low while a memory read is outstanding");
endmodule

`default_nettype wire

// ==== bench/l2_cache_tb.sv ====
// L2 cache testbench
// Applies a table of requests to the cache with a memory model behind it,
// keeps line, presence and L1 way models and checks every response packet.
// Finishes with a burst of back-to-back hits

`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;
	import l2_cache_pkg::*;

	typedef struct packed {
		l2req_op_t op;
		logic [CORE_INDEX_WIDTH-1:0] core;
		logic [STRAND_INDEX_WIDTH-1:0] strand;
		logic [L1_WAY_INDEX_WIDTH-1:0] l1_way;
		logic [ADDRESS_BITS-1:0] address;
		logic [LINE_BYTES-1:0] mask;
		logic [LINE_BITS-1:0] data;
		logic status;
		logic [NUM_CORES-1:0] update;
	} stimulus_t;

	logic clk;
	logic reset;
	logic l2req_valid;
	l2_request_t l2req;
	logic busy;
	logic l2rsp_valid;
	l2_response_t l2rsp;
	logic mem_read_valid;
	logic [ADDRESS_BITS-1:0] mem_read_address;
	logic mem_response_valid;
	logic [LINE_BITS-1:0] mem_response_data;

	stimulus_t stimulus_table [15];
	stimulus_t stream_table [4];
	logic [LINE_BITS-1:0] line_model [logic [ADDRESS_BITS-1:0]];
	logic [NUM_CORES-1:0] presence_model [logic [ADDRESS_BITS-1:0]];
	logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] way_model [logic [ADDRESS_BITS-1:0]];
	logic [15:0] lfsr_state;
	int mem_answer_count;

	l2_cache l2_cache_inst(
		.clk(clk),
		.reset(reset),
		.l2req_valid(l2req_valid),
		.l2req(l2req),
		.busy(busy),
		.l2rsp_valid(l2rsp_valid),
		.l2rsp(l2rsp),
		.mem_read_valid(mem_read_valid),
		.mem_read_address(mem_read_address),
		.mem_response_valid(mem_response_valid),
		.mem_response_data(mem_response_data));

	bind l2_cache l2_cache_assert l2_cache_assert_inst(
		.clk(clk),
		.reset(reset),
		.l2req_valid(l2req_valid),
		.busy(busy),
		.l2rsp_valid(l2rsp_valid),
		.mem_read_valid(mem_read_valid),
		.mem_response_valid(mem_response_valid));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_response(input l2_response_t actual, input l2_response_t expected,
		input string name);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
			report_failure();
		end
	endtask

	task automatic check_line(input logic [LINE_BITS-1:0] actual,
		input logic [LINE_BITS-1:0] expected, input string name);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
			report_failure();
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string name);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, actual, expected);
			report_failure();
		end
	endtask

	task automatic check_latency(input int actual, input int expected, input string name);
		if (actual != expected)
		begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, actual, expected);
			report_failure();
		end
	endtask

	// Galois LFSR stepped once per random bit
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	task automatic take_random_bits(input int count, output int value);
		value = 0;
		for (int index = 0; index < count; index++)
		begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Every word of a memory line carries the whole line address
	function automatic logic [LINE_BITS-1:0] line_pattern(input logic [ADDRESS_BITS-1:0] address);
		logic [LINE_BITS-1:0] line;
		for (int word = 0; word < LINE_BITS / 32; word++)
			line[word * 32 +: 32] = {6'(word + 1), address} ^ 32'hC3A5_0F1E;
		return line;
	endfunction

	function automatic logic [LINE_BITS-1:0] merge_bytes(input logic [LINE_BITS-1:0] line,
		input logic [LINE_BITS-1:0] data, input logic [LINE_BYTES-1:0] mask);
		logic [LINE_BITS-1:0] merged;
		for (int index = 0; index < LINE_BYTES; index++)
			merged[index * 8 +: 8] = mask[index] ? data[index * 8 +: 8] : line[index * 8 +: 8];
		return merged;
	endfunction

	function automatic stimulus_t make_entry(input l2req_op_t op,
		input logic [CORE_INDEX_WIDTH-1:0] core, input logic [STRAND_INDEX_WIDTH-1:0] strand,
		input logic [L1_WAY_INDEX_WIDTH-1:0] l1_way, input logic [ADDRESS_BITS-1:0] address,
		input logic [LINE_BYTES-1:0] mask, input logic [LINE_BITS-1:0] data, input logic status,
		input logic [NUM_CORES-1:0] update);
		stimulus_t entry;
		entry.op = op;
		entry.core = core;
		entry.strand = strand;
		entry.l1_way = l1_way;
		entry.address = address;
		entry.mask = mask;
		entry.data = data;
		entry.status = status;
		entry.update = update;
		return entry;
	endfunction

	// Lines 123, 457 and a3c sit in different sets, so nothing is evicted
	task automatic build_tables();
		stimulus_table[0] = make_entry(l2req_load, 1'b0, 2'd0, 2'd1, 26'h123, '0, '0, 1'b1, 2'b00);
		stimulus_table[1] = make_entry(l2req_load, 1'b0, 2'd0, 2'd1, 26'h123, '0, '0, 1'b1, 2'b00);
		stimulus_table[2] = make_entry(l2req_load, 1'b1, 2'd1, 2'd2, 26'h123, '0, '0, 1'b1, 2'b00);
		stimulus_table[3] = make_entry(l2req_store, 1'b0, 2'd2, 2'd1, 26'h123, 16'h00F0,
			{4{32'hDEAD_BEEF}}, 1'b1, 2'b11);
		stimulus_table[4] = make_entry(l2req_load, 1'b1, 2'd1, 2'd2, 26'h123, '0, '0, 1'b1, 2'b00);
		// A sync pair on one strand succeeds and a store from another strand breaks the next one
		stimulus_table[5] = make_entry(l2req_load_sync, 1'b0, 2'd1, 2'd0, 26'h457, '0, '0,
			1'b1, 2'b00);
		stimulus_table[6] = make_entry(l2req_store_sync, 1'b0, 2'd1, 2'd0, 26'h457, 16'h000F,
			{4{32'h1234_5678}}, 1'b1, 2'b01);
		stimulus_table[7] = make_entry(l2req_load_sync, 1'b1, 2'd3, 2'd3, 26'h457, '0, '0,
			1'b1, 2'b00);
		stimulus_table[8] = make_entry(l2req_store, 1'b0, 2'd0, 2'd0, 26'h457, 16'hF000,
			{4{32'hCAFE_F00D}}, 1'b1, 2'b11);
		stimulus_table[9] = make_entry(l2req_store_sync, 1'b1, 2'd3, 2'd3, 26'h457, 16'h0F00,
			{4{32'h0BAD_0BAD}}, 1'b0, 2'b00);
		stimulus_table[10] = make_entry(l2req_dinvalidate, 1'b0, 2'd0, 2'd1, 26'h123, '0, '0,
			1'b1, 2'b11);
		stimulus_table[11] = make_entry(l2req_store, 1'b1, 2'd0, 2'd2, 26'h123, 16'h8001,
			{4{32'h5555_AAAA}}, 1'b1, 2'b00);
		stimulus_table[12] = make_entry(l2req_flush, 1'b0, 2'd0, 2'd0, 26'h457, '0, '0, 1'b1, 2'b00);
		stimulus_table[13] = make_entry(l2req_iinvalidate, 1'b1, 2'd2, 2'd1, 26'h457, '0, '0,
			1'b1, 2'b00);
		// A store that misses merges its bytes on top of the fill
		stimulus_table[14] = make_entry(l2req_store, 1'b1, 2'd1, 2'd3, 26'hA3C, 16'h0FF0,
			{4{32'h7777_3333}}, 1'b1, 2'b00);
		stream_table[0] = make_entry(l2req_load, 1'b0, 2'd0, 2'd1, 26'h123, '0, '0, 1'b1, 2'b00);
		stream_table[1] = make_entry(l2req_load, 1'b1, 2'd2, 2'd3, 26'h457, '0, '0, 1'b1, 2'b00);
		stream_table[2] = make_entry(l2req_load, 1'b0, 2'd3, 2'd2, 26'hA3C, '0, '0, 1'b1, 2'b00);
		stream_table[3] = make_entry(l2req_load, 1'b1, 2'd1, 2'd2, 26'h123, '0, '0, 1'b1, 2'b00);
	endtask

	task automatic drive_request(input stimulus_t s);
		l2req.core = s.core;
		l2req.unit = ~s.strand;
		l2req.strand = s.strand;
		l2req.op = s.op;
		l2req.l1_way = s.l1_way;
		l2req.address = s.address;
		l2req.store_mask = s.mask;
		l2req.data = s.data;
	endtask

	task automatic wait_for_idle();
		int cycles;
		cycles = 0;
		while (busy)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 100)
			begin
				$display("Timed out waiting for busy to fall");
				report_failure();
			end
		end
	endtask

	// Holds the strobe for one edge, which is the edge that accepts it
	task automatic issue_request(input stimulus_t s);
		wait_for_idle();
		drive_request(s);
		l2req_valid = 1'b1;
		@(posedge clk);
		#1;
		l2req_valid = 1'b0;
	endtask

	task automatic wait_for_response(output int latency);
		latency = 1;
		while (!l2rsp_valid)
		begin
			@(posedge clk);
			#1;
			latency++;
			if (latency > 60)
			begin
				$display("Timed out waiting for a response");
				report_failure();
			end
		end
	endtask

	// Builds the expected packet from the models before this request changes them
	function automatic l2_response_t expected_response(input stimulus_t s);
		l2_response_t expected;
		logic [NUM_CORES-1:0] holders;
		logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] ways;
		holders = presence_model[s.address];
		ways = way_model[s.address];
		expected.status = s.status;
		expected.core = s.core;
		expected.unit = ~s.strand;
		expected.strand = s.strand;
		case (s.op)
			l2req_store, l2req_store_sync: expected.op = l2rsp_store_ack;
			l2req_dinvalidate: expected.op = l2rsp_dinvalidate;
			l2req_iinvalidate: expected.op = l2rsp_iinvalidate;
			default: expected.op = l2rsp_load_ack;
		endcase
		expected.update = s.update;
		for (int core = 0; core < NUM_CORES; core++)
		begin
			expected.way[core * L1_WAY_INDEX_WIDTH +: L1_WAY_INDEX_WIDTH] = holders[core]
				? ways[core * L1_WAY_INDEX_WIDTH +: L1_WAY_INDEX_WIDTH] : s.l1_way;
		end
		expected.address = s.address;
		if (s.op == l2req_store || (s.op == l2req_store_sync && s.status))
			expected.data = merge_bytes(line_model[s.address], s.data, s.mask);
		else
			expected.data = line_model[s.address];
		return expected;
	endfunction

	task automatic check_result(input stimulus_t s);
		l2_response_t expected;
		logic [NUM_CORES-1:0] holders;
		logic [NUM_CORES*L1_WAY_INDEX_WIDTH-1:0] ways;
		expected = expected_response(s);
		check_line(l2rsp.data, expected.data, "l2rsp.data");
		check_response(l2rsp, expected, "l2rsp");
		line_model[s.address] = expected.data;
		holders = presence_model[s.address];
		ways = way_model[s.address];
		// Loads register the core as a holder and a data invalidation drops all
		if (s.op == l2req_load || s.op == l2req_load_sync)
		begin
			holders[s.core] = 1'b1;
			ways[s.core * L1_WAY_INDEX_WIDTH +: L1_WAY_INDEX_WIDTH] = s.l1_way;
		end
		else if (s.op == l2req_dinvalidate)
			holders = '0;
		presence_model[s.address] = holders;
		way_model[s.address] = ways;
	endtask

	task automatic run_entry(input stimulus_t s);
		int latency;
		int answers_before;
		logic miss;
		miss = !line_model.exists(s.address);
		answers_before = mem_answer_count;
		issue_request(s);
		wait_for_response(latency);
		if (miss)
		begin
			if (mem_answer_count == answers_before)
			begin
				$display("Response for the miss at %h came before memory answered", s.address);
				report_failure();
			end
			// A fresh fill has the memory line and no L1 holders
			line_model[s.address] = line_pattern(s.address);
			presence_model[s.address] = '0;
			way_model[s.address] = '0;
		end
		else
			check_latency(latency, 3, "hit latency");
		check_result(s);
	endtask

	// Request k goes in on iteration k and its response shows after iteration k + 2
	task automatic run_stream();
		wait_for_idle();
		for (int step = 0; step < 6; step++)
		begin
			if (step < 4)
			begin
				drive_request(stream_table[step]);
				l2req_valid = 1'b1;
			end
			else
				l2req_valid = 1'b0;
			@(posedge clk);
			#1;
			if (step >= 2)
			begin
				if (!l2rsp_valid)
				begin
					$display("Back-to-back hit %0d gave no response 3 cycles after it", step - 2);
					report_failure();
				end
				check_result(stream_table[step - 2]);
			end
			else
				check_flag(l2rsp_valid, 1'b0, "l2rsp_valid");
		end
	endtask

	// Memory model answers each read after 2 to 9 cycles
	initial
	begin
		int delay;
		logic [ADDRESS_BITS-1:0] read_address;
		mem_response_valid = 1'b0;
		mem_response_data = '0;
		forever
		begin
			@(posedge clk);
			#1;
			if (mem_read_valid)
			begin
				read_address = mem_read_address;
				take_random_bits(3, delay);
				delay = delay + 2;
				repeat (delay - 1) @(posedge clk);
				#1;
				mem_response_valid = 1'b1;
				mem_response_data = line_pattern(read_address);
				mem_answer_count++;
				@(posedge clk);
				#1;
				mem_response_valid = 1'b0;
			end
		end
	end

	initial
	begin
		reset = 1'b1;
		l2req_valid = 1'b0;
		l2req = '0;
		mem_answer_count = 0;
		lfsr_state = 16'd16;
		build_tables();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		check_flag(l2rsp_valid, 1'b0, "l2rsp_valid");
		check_flag(mem_read_valid, 1'b0, "mem_read_valid");
		check_flag(busy, 1'b0, "busy");
		for (int index = 0; index < 15; index++)
			run_entry(stimulus_table[index]);
		run_stream();
		$display("TEST PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== compile.f ====
src/l2_cache_pkg.sv
src/l2_cache_tag.sv
src/l2_cache_read_write.sv
src/l2_cache_response.sv
src/l2_cache_fill.sv
src/l2_cache.sv
bench/l2_cache_assert.sv
bench/l2_cache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = l2_cache_tb
FILELIST = compile.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
